/* bench/raster_testdata.txt */
# Records: W addr data, R addr expected, P x y colour, D drains. Hex except x and y.
R 1f 00000000
W 10 0000c864
W 11 00002814
W 12 010000ff
W 08 00a320c8
W 09 0100ff00
W 00 0001912c
W 01 00019154
W 02 0002312c
W 03 01ff0000
R 02 0002312c
R 12 010000ff
P 110 55 0000ff
P 119 59 0000ff
P 120 55 000000
P 110 60 000000
P 210 200 00ff00
P 207 207 00ff00
P 208 207 000000
P 300 100 ff0000
P 320 120 ff0000
P 321 120 000000
D
W 12 000000ff
P 110 55 000000
D
W 04 0004b1f9
W 05 0004b208
W 06 0004edf9
W 07 01ddeeff
W 0a 00f4d9fe
W 0b 01778899
W 0c 00f4da03
W 0d 01aabbcc
W 13 000461e0
W 14 0000f03c
W 15 01112233
R 0d 01aabbcc
P 485 285 112233
P 497 310 778899
P 510 318 778899
P 528 310 aabbcc
P 508 305 ddeeff
D

/* compile.f */
hdl/raster_pkg.sv
hdl/triangle_test.sv
hdl/circle_test.sv
hdl/rect_test.sv
hdl/shape_ram.sv
hdl/shape_hit_array.sv
hdl/priority_shader.sv
hdl/raster_top.sv
bench/raster_tb.sv

/* bench/raster_tb.sv */
`timescale 1ns/1ps
module raster_tb;

    logic                ps_clk;
    logic                arst_n;
    raster_pkg::cfg_wr_t cfg_wr;
    logic                rd_en;
    raster_pkg::addr_t   rd_addr;
    raster_pkg::word_t   rd_data;
    logic                rd_valid;
    raster_pkg::point_t  pix;
    logic                pix_valid;
    logic                pix_ready;
    raster_pkg::color_t  color;
    logic                color_valid;
    logic                color_ready;

    // One entry per record of the data file.
    logic [7:0]  rec_op [$];
    logic [31:0] rec_a [$];
    logic [31:0] rec_b [$];
    logic [31:0] rec_c [$];

    // Colours expected in order, with the cycle each pixel was accepted.
    raster_pkg::color_t exp_q [$];
    int                 acc_q [$];
    int                 cycle = 0;
    int                 limit = 0;
    int                 last_low = 0;
    int                 timed_checks = 0;

    // Output seen stalled on the previous edge.
    logic               held_valid = 1'b0;
    raster_pkg::color_t held_color;

    raster_top raster_top_inst (.*);

    initial
    begin
        ps_clk = 1'b0;
        forever #5 ps_clk = ~ps_clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic clear_inputs();
        cfg_wr.en = 1'b0;
        rd_en     = 1'b0;
        pix_valid = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(negedge ps_clk);
        clear_inputs();
        cfg_wr.en   = 1'b1;
        cfg_wr.addr = addr[4:0];
        cfg_wr.data = data;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [31:0] expected);
        @(negedge ps_clk);
        assert (!rd_valid)
        else
            stop_run($sformatf("[FAIL] %0t: rd_valid high with no read pending", $time));
        clear_inputs();
        rd_en   = 1'b1;
        rd_addr = addr[4:0];
        @(negedge ps_clk);
        rd_en = 1'b0;
        assert (rd_valid && rd_data == expected)
        else
            stop_run($sformatf("[FAIL] %0t: read %h gave valid %b data %h, expected %h",
                               $time, addr[4:0], rd_valid, rd_data, expected));
    endtask

    task automatic send_pixel(input logic [31:0] x, input logic [31:0] y,
                              input logic [31:0] expected);
        @(negedge ps_clk);
        clear_inputs();
        pix.x     = x[9:0];
        pix.y     = y[9:0];
        pix_valid = 1'b1;
        @(posedge ps_clk);
        while (!pix_ready)
            @(posedge ps_clk);
        exp_q.push_back(expected[23:0]);
        acc_q.push_back(cycle);
    endtask

    task automatic drain();
        @(negedge ps_clk);
        clear_inputs();
        while (exp_q.size() != 0)
            @(negedge ps_clk);
    endtask

    always @(negedge ps_clk)
    begin
        cycle = cycle + 1;
        if (limit > 0 && cycle > limit)
            stop_run($sformatf("Run timed out after %0d cycles.", cycle));
    end

    initial
    begin
        int unused_seed;
        unused_seed = $urandom(32'h4eb3);
        color_ready = 1'b0;
        forever
        begin
            @(negedge ps_clk);
            color_ready = ($urandom % 4) != 0;
        end
    end

    always @(posedge ps_clk)
    begin
        raster_pkg::color_t want;
        int                 acc;
        if (held_valid)
        begin
            assert (color_valid && color == held_color)
            else
                stop_run($sformatf("[FAIL] %0t: held colour valid %b data %h, expected %h",
                                   $time, color_valid, color, held_color));
        end
        held_valid = arst_n && color_valid && !color_ready;
        held_color = color;
        if (!color_ready)
            last_low = cycle;
        if (arst_n && color_valid && color_ready)
        begin
            assert (exp_q.size() > 0)
            else
                stop_run("A colour left the DUT with no pixel pending.");
            want = exp_q.pop_front();
            acc  = acc_q.pop_front();
            assert (color == want)
            else
                stop_run($sformatf("[FAIL] %0t: colour %h, expected %h", $time, color, want));
            // Ready high on every edge since the accept means no stall.
            if (last_low <= acc)
            begin
                timed_checks++;
                assert (cycle - acc == 2)
                else
                    stop_run($sformatf("[FAIL] %0t: colour after %0d cycles, expected 2",
                                       $time, cycle - acc));
            end
        end
    end

    initial
    begin
        int              fd;
        int              n;
        logic [63:0]     tok;
        logic [8*160-1:0] line;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        arst_n    = 1'b0;
        cfg_wr    = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        pix       = '0;
        pix_valid = 1'b0;

        fd = $fopen("bench/raster_testdata.txt", "r");
        assert (fd != 0)
        else
            stop_run("Could not open bench/raster_testdata.txt.");
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%s", tok);
            if (n == 1)
            begin
                a = '0;
                b = '0;
                c = '0;
                case (tok)
                    "#": n = $fgets(line, fd);
                    "W", "R": n = $fscanf(fd, "%h %h", a, b);
                    "P": n = $fscanf(fd, "%d %d %h", a, b, c);
                    "D": n = 0;
                    default: stop_run($sformatf("Unknown record %0s in the data file.", tok));
                endcase
                if (tok != "#")
                begin
                    rec_op.push_back(tok[7:0]);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                end
            end
        end
        $fclose(fd);
        limit = 20 * rec_op.size() + 100;

        repeat (3) @(posedge ps_clk);
        @(negedge ps_clk);
        arst_n = 1'b1;
        assert (!rd_valid && !color_valid && pix_ready)
        else
            stop_run($sformatf("[FAIL] %0t: idle state after reset is wrong", $time));

        for (int i = 0; i < rec_op.size(); i++)
        begin
            case (rec_op[i])
                "W": write_word(rec_a[i], rec_b[i]);
                "R": read_word(rec_a[i], rec_b[i]);
                "P": send_pixel(rec_a[i], rec_b[i], rec_c[i]);
                default: drain();
            endcase
        end
        drain();

        assert (timed_checks > 0)
            $display("Result: PASSED");
        else
            stop_run("No colour was timed with the output held ready.");
        $finish;
    end

endmodule

/* hdl/raster_top.sv */
`timescale 1ns/1ps
module raster_top (
    input  logic                ps_clk,
    input  logic                arst_n,
    input  raster_pkg::cfg_wr_t cfg_wr,
    input  logic                rd_en,
    input  raster_pkg::addr_t   rd_addr,
    output raster_pkg::word_t   rd_data,
    output logic                rd_valid,
    input  raster_pkg::point_t  pix,
    input  logic                pix_valid,
    output logic                pix_ready,
    output raster_pkg::color_t  color,
    output logic                color_valid,
    input  logic                color_ready
);

    raster_pkg::tri_set_t   tri_set;
    raster_pkg::circ_set_t  circ_set;
    raster_pkg::rect_set_t  rect_set;
    raster_pkg::color_set_t color_set;
    raster_pkg::hit_vec_t   s1_hits;
    logic                   s1_valid;
    logic                   s1_ready;

    shape_ram shape_ram_inst (
        .ps_clk    (ps_clk),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .tri_set   (tri_set),
        .circ_set  (circ_set),
        .rect_set  (rect_set),
        .color_set (color_set)
    );

    // Stage 1 pixel copy is not needed downstream.
    shape_hit_array shape_hit_array_inst (
        .ps_clk    (ps_clk),
        .arst_n    (arst_n),
        .pix       (pix),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .tri_set   (tri_set),
        .circ_set  (circ_set),
        .rect_set  (rect_set),
        .s1_valid  (s1_valid),
        .s1_ready  (s1_ready),
        .s1_hits   (s1_hits),
        .s1_pix    ()
    );

    priority_shader priority_shader_inst (
        .ps_clk      (ps_clk),
        .arst_n      (arst_n),
        .s1_valid    (s1_valid),
        .s1_ready    (s1_ready),
        .s1_hits     (s1_hits),
        .color_set   (color_set),
        .color       (color),
        .color_valid (color_valid),
        .color_ready (color_ready)
    );

endmodule

/* hdl/priority_shader.sv */
`timescale 1ns/1ps
module priority_shader (
    input  logic                   ps_clk,
    input  logic                   arst_n,
    input  logic                   s1_valid,
    output logic                   s1_ready,
    input  raster_pkg::hit_vec_t   s1_hits,
    input  raster_pkg::color_set_t color_set,
    output raster_pkg::color_t     color,
    output logic                   color_valid,
    input  logic                   color_ready
);

    raster_pkg::color_t sel_color;

    // Walk from the lowest priority up so the lowest set index wins.
    always_comb
    begin
        sel_color = raster_pkg::bg_color;
        for (int i = raster_pkg::num_shapes - 1; i >= 0; i--)
        begin
            if (s1_hits[i])
                sel_color = color_set[i];
        end
    end

    assign s1_ready = !color_valid || color_ready;

    always_ff @(posedge ps_clk or negedge arst_n)
    begin
        if (!arst_n)
            color_valid <= 1'b0;
        else if (s1_ready)
            color_valid <= s1_valid;
    end

    // Output holds while stalled.
    always_ff @(posedge ps_clk)
    begin
        if (s1_valid && s1_ready)
            color <= sel_color;
    end

endmodule

/* hdl/shape_hit_array.sv */
`timescale 1ns/1ps
module shape_hit_array (
    input  logic                  ps_clk,
    input  logic                  arst_n,
    input  raster_pkg::point_t    pix,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  raster_pkg::tri_set_t  tri_set,
    input  raster_pkg::circ_set_t circ_set,
    input  raster_pkg::rect_set_t rect_set,
    output logic                  s1_valid,
    input  logic                  s1_ready,
    output raster_pkg::hit_vec_t  s1_hits,
    output raster_pkg::point_t    s1_pix
);

    raster_pkg::hit_vec_t hits;

    // Hit vector in priority order: triangles, circles, rectangles.
    for (genvar t = 0; t < raster_pkg::num_tri; t++)
    begin : g_tri
        triangle_test triangle_test_inst (
            .pix  (pix),
            .desc (tri_set[t]),
            .hit  (hits[t])
        );
    end

    for (genvar c = 0; c < raster_pkg::num_circ; c++)
    begin : g_circ
        circle_test circle_test_inst (
            .pix  (pix),
            .desc (circ_set[c]),
            .hit  (hits[raster_pkg::num_tri + c])
        );
    end

    for (genvar r = 0; r < raster_pkg::num_rect; r++)
    begin : g_rect
        rect_test rect_test_inst (
            .pix  (pix),
            .desc (rect_set[r]),
            .hit  (hits[raster_pkg::num_tri + raster_pkg::num_circ + r])
        );
    end

    // Take a new pixel when the slot is empty or being drained.
    assign pix_ready = !s1_valid || s1_ready;

    always_ff @(posedge ps_clk or negedge arst_n)
    begin
        if (!arst_n)
            s1_valid <= 1'b0;
        else if (pix_ready)
            s1_valid <= pix_valid;
    end

    always_ff @(posedge ps_clk)
    begin
        if (pix_valid && pix_ready)
        begin
            s1_hits <= hits;
            s1_pix  <= pix;
        end
    end

endmodule

/* hdl/shape_ram.sv */
`timescale 1ns/1ps
module shape_ram (
    input  logic                   ps_clk,
    input  logic                   arst_n,
    input  raster_pkg::cfg_wr_t    cfg_wr,
    input  logic                   rd_en,
    input  raster_pkg::addr_t      rd_addr,
    output raster_pkg::word_t      rd_data,
    output logic                   rd_valid,
    output raster_pkg::tri_set_t   tri_set,
    output raster_pkg::circ_set_t  circ_set,
    output raster_pkg::rect_set_t  rect_set,
    output raster_pkg::color_set_t color_set
);

    raster_pkg::word_t mem [raster_pkg::mem_words];

    always_ff @(posedge ps_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < raster_pkg::mem_words; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (cfg_wr.en)
        begin
            mem[cfg_wr.addr] <= cfg_wr.data;
        end
    end

    always_ff @(posedge ps_clk or negedge arst_n)
    begin
        if (!arst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_en;
    end

    always_ff @(posedge ps_clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

    // Slice the word map into descriptors; the colour word closes each slot.
    for (genvar t = 0; t < raster_pkg::num_tri; t++)
    begin : g_tri
        localparam int base = raster_pkg::tri_base + t * raster_pkg::words_per_tri;
        localparam int cw   = base + raster_pkg::words_per_tri - 1;
        assign tri_set[t].v0     = mem[base][19:0];
        assign tri_set[t].v1     = mem[base + 1][19:0];
        assign tri_set[t].v2     = mem[base + 2][19:0];
        assign tri_set[t].active = mem[cw][raster_pkg::active_bit];
        assign color_set[t]      = mem[cw][23:0];
    end

    for (genvar c = 0; c < raster_pkg::num_circ; c++)
    begin : g_circ
        localparam int base = raster_pkg::circ_base + c * raster_pkg::words_per_circ;
        localparam int cw   = base + raster_pkg::words_per_circ - 1;
        assign circ_set[c].center = mem[base][19:0];
        assign circ_set[c].radius = mem[base][29:20];
        assign circ_set[c].active = mem[cw][raster_pkg::active_bit];
        assign color_set[raster_pkg::num_tri + c] = mem[cw][23:0];
    end

    for (genvar r = 0; r < raster_pkg::num_rect; r++)
    begin : g_rect
        localparam int base = raster_pkg::rect_base + r * raster_pkg::words_per_rect;
        localparam int cw   = base + raster_pkg::words_per_rect - 1;
        assign rect_set[r].origin = mem[base][19:0];
        assign rect_set[r].w      = mem[base + 1][9:0];
        assign rect_set[r].h      = mem[base + 1][19:10];
        assign rect_set[r].active = mem[cw][raster_pkg::active_bit];
        assign color_set[raster_pkg::num_tri + raster_pkg::num_circ + r] = mem[cw][23:0];
    end

endmodule

/* hdl/rect_test.sv */
`timescale 1ns/1ps
module rect_test (
    input  raster_pkg::point_t     pix,
    input  raster_pkg::rect_desc_t desc,
    output logic                   hit
);

    logic [10:0] x_end;
    logic [10:0] y_end;
    logic        in_x;
    logic        in_y;

    // One extra bit so origin plus size never wraps.
    assign x_end = desc.origin.x + desc.w;
    assign y_end = desc.origin.y + desc.h;

    assign in_x = (pix.x >= desc.origin.x) && ({1'b0, pix.x} < x_end);
    assign in_y = (pix.y >= desc.origin.y) && ({1'b0, pix.y} < y_end);

    assign hit = desc.active && in_x && in_y;

endmodule

/* hdl/circle_test.sv */
`timescale 1ns/1ps
module circle_test (
    input  raster_pkg::point_t     pix,
    input  raster_pkg::circ_desc_t desc,
    output logic                   hit
);

    raster_pkg::coord_t dx;
    raster_pkg::coord_t dy;
    logic [19:0]        dx_sq;
    logic [19:0]        dy_sq;
    logic [20:0]        dist_sq;
    logic [19:0]        rad_sq;

    // Absolute distances keep the squares unsigned.
    assign dx = (pix.x >= desc.center.x) ? pix.x - desc.center.x : desc.center.x - pix.x;
    assign dy = (pix.y >= desc.center.y) ? pix.y - desc.center.y : desc.center.y - pix.y;

    assign dx_sq   = dx * dx;
    assign dy_sq   = dy * dy;
    assign dist_sq = dx_sq + dy_sq;
    assign rad_sq  = desc.radius * desc.radius;

    assign hit = desc.active && (dist_sq <= {1'b0, rad_sq});

endmodule

/* hdl/triangle_test.sv */
`timescale 1ns/1ps
module triangle_test (
    input  raster_pkg::point_t    pix,
    input  raster_pkg::tri_desc_t desc,
    output logic                  hit
);

    logic signed [22:0] cross0;
    logic signed [22:0] cross1;
    logic signed [22:0] cross2;
    logic               all_pos;
    logic               all_neg;

    // Cross product of edge a->b with a->p; sign tells which side p is on.
    function automatic logic signed [22:0] edge_cross(
        input raster_pkg::point_t a,
        input raster_pkg::point_t b,
        input raster_pkg::point_t p
    );
        logic signed [10:0] ex;
        logic signed [10:0] ey;
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        ex = $signed({1'b0, b.x}) - $signed({1'b0, a.x});
        ey = $signed({1'b0, b.y}) - $signed({1'b0, a.y});
        dx = $signed({1'b0, p.x}) - $signed({1'b0, a.x});
        dy = $signed({1'b0, p.y}) - $signed({1'b0, a.y});
        return ex * dy - ey * dx;
    endfunction

    assign cross0 = edge_cross(desc.v0, desc.v1, pix);
    assign cross1 = edge_cross(desc.v1, desc.v2, pix);
    assign cross2 = edge_cross(desc.v2, desc.v0, pix);

    // Zero counts on both sides, so edges are inside for either winding.
    assign all_pos = (cross0 >= 0) && (cross1 >= 0) && (cross2 >= 0);
    assign all_neg = (cross0 <= 0) && (cross1 <= 0) && (cross2 <= 0);

    assign hit = desc.active && (all_pos || all_neg);

endmodule

/* hdl/raster_pkg.sv */
package raster_pkg;

    // Shape counts and memory size.
    localparam int num_tri    = 2;
    localparam int num_circ   = 4;
    localparam int num_rect   = 4;
    localparam int num_shapes = num_tri + num_circ + num_rect;
    localparam int mem_words  = 32;

    // First word of each shape group and the words in one slot.
    localparam int tri_base       = 0;
    localparam int circ_base      = 8;
    localparam int rect_base      = 16;
    localparam int words_per_tri  = 4;
    localparam int words_per_circ = 2;
    localparam int words_per_rect = 3;

    // Enable flag inside every colour word.
    localparam int active_bit = 24;

    typedef logic [9:0]            coord_t;
    typedef logic [23:0]           color_t;
    typedef logic [31:0]           word_t;
    typedef logic [4:0]            addr_t;
    typedef logic [num_shapes-1:0] hit_vec_t;

    localparam color_t bg_color = 24'h000000;

    // Low half matches the x field of a vertex word.
    typedef struct packed {
        coord_t y;
        coord_t x;
    } point_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } cfg_wr_t;

    typedef struct packed {
        logic   active;
        point_t v2;
        point_t v1;
        point_t v0;
    } tri_desc_t;

    typedef struct packed {
        logic   active;
        coord_t radius;
        point_t center;
    } circ_desc_t;

    typedef struct packed {
        logic   active;
        coord_t h;
        coord_t w;
        point_t origin;
    } rect_desc_t;

    typedef tri_desc_t  [num_tri-1:0]    tri_set_t;
    typedef circ_desc_t [num_circ-1:0]   circ_set_t;
    typedef rect_desc_t [num_rect-1:0]   rect_set_t;
    // Index 0 has the highest priority.
    typedef color_t     [num_shapes-1:0] color_set_t;

endpackage
